// File: common/sysregs_map_pkg.sv
// system register map
// window offsets, register selects and the bit layout of RMBCTRL and SYSCTRL
`default_nettype none

package sysregs_map_pkg;

    typedef logic [4:0] reg_off_t;          // offset within the $9F50-$9F6F window

    // raw offsets carry the top bit inverted, so $9F50 sits at offset $10
    localparam reg_off_t OFF_BLOCK_AB   = 5'h10;    // $9F50, mirrored at $00
    localparam reg_off_t OFF_BLOCK_CF   = 5'h11;    // $9F51, mirrored at $01
    localparam reg_off_t OFF_BLOCK_MASK = 5'h12;    // $9F52
    localparam reg_off_t OFF_RMBCTRL    = 5'h13;    // $9F53
    localparam reg_off_t OFF_SYSCTRL    = 5'h14;    // $9F54

    typedef enum logic [2:0] {
        REG_NONE,                           // unkept offset, reads zero
        REG_BLOCK_AB,
        REG_BLOCK_CF,
        REG_BLOCK_MASK,
        REG_RMBCTRL,
        REG_SYSCTRL
    } reg_sel_t;

    // RMBCTRL bits
    localparam int RMB_BOOTROM    = 7;      // bootrom mapped at $E000
    localparam int RMB_AUTO_UNMAP = 6;      // unmap bootrom after RTI
    localparam int RMB_MIRROR_ZP  = 5;      // block regs mirrored to $00/$01
    localparam int RMB_ROM_CF     = 4;      // ROM blocks in $C000-$FFFF
    localparam int RMB_RAM_CF     = 3;      // second RAM block at $C000
    localparam int RMB_RDONLY_LO  = 1;      // read-only field is bits 2:1

    // SYSCTRL
    localparam logic [7:0] SYS_UNLOCK_KEY = 8'h80;
    localparam int SYS_ABRT02   = 6;
    localparam int SYS_CPUSTOP  = 1;
    localparam int SYS_CPURESET = 0;

    localparam logic [7:0] RMBCTRL_RESET = 8'h80;   // PBL runs from bootrom
    localparam logic [7:0] MASK_RESET    = 8'hFF;   // whole SRAM reachable

endpackage

`default_nettype wire

// File: common/memmap_pkg.sv
// SRAM memory map
// block number type and the fixed blocks behind the CPU windows
`default_nettype none

package memmap_pkg;

    typedef logic [7:0] block_t;            // 8 KB SRAM block number

    // RAM block numbers are stored flipped so that user block 0 lands at SRAM $80
    localparam block_t BLOCK_FLIP = 8'h80;

    // fixed RAM blocks when nothing else is mapped
    localparam block_t BLOCK_CD_FIXED = 8'h06;      // $C000-$DFFF
    localparam block_t BLOCK_EF_FIXED = 8'h07;      // $E000-$FFFF and vector pull

    // ROM block n occupies two SRAM blocks starting here
    // the low one for $C000, the high one for $E000
    localparam block_t ROM_BLOCK_BASE = 8'h40;

endpackage

`default_nettype wire

// File: verilog/reg_decode.sv
// register address decode
// maps a window offset or the zero-page mirror onto a register select
// and qualifies bus writes into strobes for the register stage
`timescale 1ns/1ns
`default_nettype none

module reg_decode (
    input  wire sysregs_map_pkg::reg_off_t slv_addr_i,
    input  wire                            slv_req_i,          // window chip select
    input  wire                            slv_req_bregs_i,    // zero-page $00/$01 access
    input  wire                            slv_rwn_i,          // 1 = read
    input  wire                            slv_datawr_valid_i,
    output sysregs_map_pkg::reg_sel_t      rd_sel_o,
    output logic                           reg_wr_o,           // write to one of the plain regs
    output logic                           sys_wr_o            // write to SYSCTRL
);
    import sysregs_map_pkg::*;

    logic wr_q;     // qualified write cycle

    always_comb
    begin
        if (slv_req_bregs_i)
        begin
            // zero-page mirror, only bit 0 matters
            rd_sel_o = slv_addr_i[0] ? REG_BLOCK_CF : REG_BLOCK_AB;
        end
        else
        begin
            case (slv_addr_i)
                OFF_BLOCK_AB:   rd_sel_o = REG_BLOCK_AB;
                OFF_BLOCK_CF:   rd_sel_o = REG_BLOCK_CF;
                OFF_BLOCK_MASK: rd_sel_o = REG_BLOCK_MASK;
                OFF_RMBCTRL:    rd_sel_o = REG_RMBCTRL;
                OFF_SYSCTRL:    rd_sel_o = REG_SYSCTRL;
                default:        rd_sel_o = REG_NONE;    // old peripheral slots and holes
            endcase
        end
    end

    // the zero-page strobe acts as its own chip select
    assign wr_q = (slv_req_i || slv_req_bregs_i) && !slv_rwn_i && slv_datawr_valid_i;

    assign reg_wr_o = wr_q && (rd_sel_o != REG_NONE) && (rd_sel_o != REG_SYSCTRL);
    assign sys_wr_o = wr_q && (rd_sel_o == REG_SYSCTRL);

endmodule

`default_nettype wire

// File: verilog/sysreg_file.sv
// system register file
// holds the block registers, the block mask and RMBCTRL, applies the
// bootrom map/unmap strobes and drives the combinational read data
`timescale 1ns/1ns
`default_nettype none

module sysreg_file (
    input  wire                            clk,
    input  wire                            resetn,
    input  wire sysregs_map_pkg::reg_sel_t rd_sel_i,
    input  wire                            reg_wr_i,
    input  wire [7:0]                      slv_datawr_i,
    input  wire                            map_bootrom_i,      // force bootrom in
    input  wire                            unmap_bootrom_i,    // drop bootrom and auto-unmap
    input  wire                            abrt02_en_i,        // SYSCTRL readback
    output logic [7:0]                     slv_datard_o,
    output memmap_pkg::block_t             block_ab_o,
    output memmap_pkg::block_t             block_cf_o,
    output memmap_pkg::block_t             block_mask_o,
    output logic [7:0]                     rmbctrl_o,
    output logic                           bootrom_in_block_ef_o,
    output logic                           auto_unmap_bootrom_o,
    output logic                           mirror_bregs_zp_o,
    output logic [1:0]                     rdonly_cdef_o       // [1] = $E000, [0] = $C000
);
    import sysregs_map_pkg::*;
    import memmap_pkg::*;

    block_t     block_ab_r;         // $9F50 / $00
    block_t     block_cf_r;         // $9F51 / $01, RAM block CD or ROM block
    block_t     block_mask_r;       // $9F52
    logic [7:0] rmbctrl_r;          // $9F53
    logic [7:0] rmbctrl_nxt;

    // RMBCTRL next value
    // strobes from the bus controller win over a CPU write in the same cycle
    always_comb
    begin
        rmbctrl_nxt = rmbctrl_r;
        if (unmap_bootrom_i)
        begin
            rmbctrl_nxt[RMB_BOOTROM]    = 1'b0;
            rmbctrl_nxt[RMB_AUTO_UNMAP] = 1'b0;
        end
        else if (map_bootrom_i)
        begin
            rmbctrl_nxt[RMB_BOOTROM] = 1'b1;    // ISAFIX handler entry
        end
        else if (reg_wr_i && rd_sel_i == REG_RMBCTRL)
        begin
            rmbctrl_nxt = slv_datawr_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            block_ab_r   <= '0;
            block_cf_r   <= '0;
            block_mask_r <= MASK_RESET;
            rmbctrl_r    <= RMBCTRL_RESET;
        end
        else
        begin
            if (reg_wr_i && rd_sel_i == REG_BLOCK_AB)
                block_ab_r <= slv_datawr_i;
            if (reg_wr_i && rd_sel_i == REG_BLOCK_CF)
                block_cf_r <= slv_datawr_i;
            if (reg_wr_i && rd_sel_i == REG_BLOCK_MASK)
                block_mask_r <= slv_datawr_i;
            rmbctrl_r <= rmbctrl_nxt;
        end
    end

    // read data follows the address in the same cycle
    always_comb
    begin
        slv_datard_o = '0;
        case (rd_sel_i)
            REG_BLOCK_AB:   slv_datard_o = block_ab_r;
            REG_BLOCK_CF:   slv_datard_o = block_cf_r;
            REG_BLOCK_MASK: slv_datard_o = block_mask_r;
            REG_RMBCTRL:    slv_datard_o = rmbctrl_r;
            REG_SYSCTRL:    slv_datard_o[SYS_ABRT02] = abrt02_en_i;   // only ABRT02 is visible
            default:        slv_datard_o = '0;
        endcase
    end

    assign block_ab_o   = block_ab_r;
    assign block_cf_o   = block_cf_r;
    assign block_mask_o = block_mask_r;
    assign rmbctrl_o    = rmbctrl_r;

    // flags for the bus controller
    assign bootrom_in_block_ef_o = rmbctrl_r[RMB_BOOTROM];
    assign auto_unmap_bootrom_o  = rmbctrl_r[RMB_AUTO_UNMAP];
    assign mirror_bregs_zp_o     = rmbctrl_r[RMB_MIRROR_ZP];
    assign rdonly_cdef_o         = rmbctrl_r[RMB_RDONLY_LO +: 2];

endmodule

`default_nettype wire

// File: verilog/sysctrl_guard.sv
// SYSCTRL guard
// the register takes a value only after an unlock key write and locks
// itself again afterwards; CPU stop and reset requests are 1-cycle pulses
`timescale 1ns/1ns
`default_nettype none

module sysctrl_guard (
    input  wire       clk,
    input  wire       resetn,
    input  wire       sys_wr_i,         // qualified SYSCTRL write
    input  wire [7:0] slv_datawr_i,
    output logic      abrt02_en_o,
    output logic      cpu_stop_req_o,
    output logic      cpu_reset_req_o
);
    import sysregs_map_pkg::*;

    logic unlocked_r;   // key seen, next plain write is accepted

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            unlocked_r      <= 1'b0;
            abrt02_en_o     <= 1'b0;
            cpu_stop_req_o  <= 1'b0;
            cpu_reset_req_o <= 1'b0;
        end
        else
        begin
            cpu_stop_req_o  <= 1'b0;        // pulses drop after one cycle
            cpu_reset_req_o <= 1'b0;
            if (sys_wr_i)
            begin
                if (slv_datawr_i == SYS_UNLOCK_KEY)
                    unlocked_r <= 1'b1;
                else if (unlocked_r && !slv_datawr_i[7])
                begin
                    abrt02_en_o     <= slv_datawr_i[SYS_ABRT02];
                    cpu_stop_req_o  <= slv_datawr_i[SYS_CPUSTOP];
                    cpu_reset_req_o <= slv_datawr_i[SYS_CPURESET];
                    unlocked_r      <= 1'b0;    // one shot, relock
                end
                // other values with bit 7 set change nothing
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/block_mapper.sv
// block mapper
// registers the SRAM block numbers seen by the bus controller for the
// $A000, $C000 and $E000 windows, plus the vector-pull block
`timescale 1ns/1ns
`default_nettype none

module block_mapper (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire memmap_pkg::block_t block_ab_i,
    input  wire memmap_pkg::block_t block_cf_i,
    input  wire memmap_pkg::block_t block_mask_i,
    input  wire [7:0]               rmbctrl_i,
    output memmap_pkg::block_t      mm_block_ab_o,      // $A000-$BFFF
    output memmap_pkg::block_t      mm_block_cd_o,      // $C000-$DFFF
    output memmap_pkg::block_t      mm_block_ef_o,      // $E000-$FFFF normal access
    output memmap_pkg::block_t      mm_vp_block_ef_o    // $E000-$FFFF vector pull
);
    import sysregs_map_pkg::*;
    import memmap_pkg::*;

    block_t rom_cd;     // low half of the selected ROM block
    block_t ram_cd;
    block_t cd_nxt;
    block_t ef_nxt;
    block_t vp_nxt;

    // ROM block n starts at base + 2n, 32 ROM blocks
    assign rom_cd = ROM_BLOCK_BASE + block_t'({block_cf_i[4:0], 1'b0});
    assign ram_cd = (block_cf_i & block_mask_i) ^ BLOCK_FLIP;

    always_comb
    begin
        if (rmbctrl_i[RMB_ROM_CF])
        begin
            cd_nxt = rom_cd;
            ef_nxt = rom_cd + 8'd1;
            vp_nxt = ROM_BLOCK_BASE + 8'd1;     // vectors always from ROM block 0
        end
        else
        begin
            cd_nxt = rmbctrl_i[RMB_RAM_CF] ? ram_cd : BLOCK_CD_FIXED;
            ef_nxt = BLOCK_EF_FIXED;
            vp_nxt = BLOCK_EF_FIXED;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            // values the reset register contents would give
            mm_block_ab_o    <= BLOCK_FLIP;
            mm_block_cd_o    <= BLOCK_CD_FIXED;
            mm_block_ef_o    <= BLOCK_EF_FIXED;
            mm_vp_block_ef_o <= BLOCK_EF_FIXED;
        end
        else
        begin
            mm_block_ab_o    <= (block_ab_i & block_mask_i) ^ BLOCK_FLIP;
            mm_block_cd_o    <= cd_nxt;
            mm_block_ef_o    <= ef_nxt;
            mm_vp_block_ef_o <= vp_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sysregs_top.sv
// system register block top
// chains address decode, register state and block mapping
`timescale 1ns/1ns
`default_nettype none

module sysregs_top (
    input  wire                            clk,
    input  wire                            resetn,
    // register slave bus
    input  wire sysregs_map_pkg::reg_off_t slv_addr_i,
    input  wire [7:0]                      slv_datawr_i,
    input  wire                            slv_datawr_valid_i,
    output logic [7:0]                     slv_datard_o,
    input  wire                            slv_req_i,
    input  wire                            slv_req_bregs_i,
    input  wire                            slv_rwn_i,
    // block mapping
    output memmap_pkg::block_t             mm_block_ab_o,
    output memmap_pkg::block_t             mm_block_cd_o,
    output memmap_pkg::block_t             mm_block_ef_o,
    output memmap_pkg::block_t             mm_vp_block_ef_o,
    output logic                           bootrom_in_block_ef_o,
    output logic                           auto_unmap_bootrom_o,
    output logic                           mirror_bregs_zp_o,
    output logic [1:0]                     rdonly_cdef_o,
    input  wire                            map_bootrom_i,
    input  wire                            unmap_bootrom_i,
    // SYSCTRL
    output logic                           abrt02_en_o,
    output logic                           cpu_stop_req_o,
    output logic                           cpu_reset_req_o
);
    import sysregs_map_pkg::*;
    import memmap_pkg::*;

    reg_sel_t   rd_sel;
    logic       reg_wr;
    logic       sys_wr;
    block_t     block_ab;
    block_t     block_cf;
    block_t     block_mask;
    logic [7:0] rmbctrl;

    reg_decode u_decode (
        .slv_addr_i         (slv_addr_i),
        .slv_req_i          (slv_req_i),
        .slv_req_bregs_i    (slv_req_bregs_i),
        .slv_rwn_i          (slv_rwn_i),
        .slv_datawr_valid_i (slv_datawr_valid_i),
        .rd_sel_o           (rd_sel),
        .reg_wr_o           (reg_wr),
        .sys_wr_o           (sys_wr)
    );

    sysreg_file u_regs (
        .clk                   (clk),
        .resetn                (resetn),
        .rd_sel_i              (rd_sel),
        .reg_wr_i              (reg_wr),
        .slv_datawr_i          (slv_datawr_i),
        .map_bootrom_i         (map_bootrom_i),
        .unmap_bootrom_i       (unmap_bootrom_i),
        .abrt02_en_i           (abrt02_en_o),      // fed back for readback
        .slv_datard_o          (slv_datard_o),
        .block_ab_o            (block_ab),
        .block_cf_o            (block_cf),
        .block_mask_o          (block_mask),
        .rmbctrl_o             (rmbctrl),
        .bootrom_in_block_ef_o (bootrom_in_block_ef_o),
        .auto_unmap_bootrom_o  (auto_unmap_bootrom_o),
        .mirror_bregs_zp_o     (mirror_bregs_zp_o),
        .rdonly_cdef_o         (rdonly_cdef_o)
    );

    sysctrl_guard u_sysctrl (
        .clk             (clk),
        .resetn          (resetn),
        .sys_wr_i        (sys_wr),
        .slv_datawr_i    (slv_datawr_i),
        .abrt02_en_o     (abrt02_en_o),
        .cpu_stop_req_o  (cpu_stop_req_o),
        .cpu_reset_req_o (cpu_reset_req_o)
    );

    block_mapper u_mapper (
        .clk              (clk),
        .resetn           (resetn),
        .block_ab_i       (block_ab),
        .block_cf_i       (block_cf),
        .block_mask_i     (block_mask),
        .rmbctrl_i        (rmbctrl),
        .mm_block_ab_o    (mm_block_ab_o),
        .mm_block_cd_o    (mm_block_cd_o),
        .mm_block_ef_o    (mm_block_ef_o),
        .mm_vp_block_ef_o (mm_vp_block_ef_o)
    );

endmodule

`default_nettype wire

// File: sim/tb_sysregs_vectors.svh
// vector table for the system register testbench
// each row holds an operation, zero-page path, offset, write data and expected value
// expected is a byte for reads, {ab, cd, ef, vp} for map checks,
// {bootrom, auto-unmap, mirror, rdonly[1:0]} for flags and {stop, reset} for pulses
`ifndef TB_SYSREGS_VECTORS_SVH
`define TB_SYSREGS_VECTORS_SVH

localparam int NUM_ROWS = 59;

row_t vectors [NUM_ROWS] = '{
    // reset values
    '{OP_RD,       1'b0, 5'h10, 8'h00, 32'h0000_0000},
    '{OP_RD,       1'b0, 5'h11, 8'h00, 32'h0000_0000},
    '{OP_RD,       1'b0, 5'h12, 8'h00, 32'h0000_00FF},
    '{OP_RD,       1'b0, 5'h13, 8'h00, 32'h0000_0080},
    '{OP_RD,       1'b0, 5'h14, 8'h00, 32'h0000_0000},
    '{OP_CHKMAP,   1'b0, 5'h00, 8'h00, 32'h8006_0707},
    '{OP_FLAGS,    1'b0, 5'h00, 8'h00, 32'h0000_0010},   // only bootrom mapped
    // random readback through the window and then the zero page
    '{OP_RND,      1'b0, 5'h10, 8'h00, 32'h0000_0000},
    '{OP_RND,      1'b0, 5'h11, 8'h00, 32'h0000_0000},
    '{OP_RND,      1'b0, 5'h12, 8'h00, 32'h0000_0000},
    '{OP_RND,      1'b0, 5'h13, 8'h00, 32'h0000_0000},
    '{OP_RND,      1'b1, 5'h00, 8'h00, 32'h0000_0000},
    '{OP_RND,      1'b1, 5'h01, 8'h00, 32'h0000_0000},
    // block mapping
    '{OP_WR,       1'b0, 5'h10, 8'h05, 32'h0000_0000},
    '{OP_WR,       1'b0, 5'h11, 8'h23, 32'h0000_0000},
    '{OP_WR,       1'b0, 5'h12, 8'hFF, 32'h0000_0000},
    '{OP_WR,       1'b0, 5'h13, 8'h10, 32'h0000_0000},   // ROM in $C000-$FFFF
    '{OP_CHKMAP,   1'b0, 5'h00, 8'h00, 32'h8546_4741},
    '{OP_WR,       1'b0, 5'h13, 8'h08, 32'h0000_0000},   // RAM block at $C000
    '{OP_CHKMAP,   1'b0, 5'h00, 8'h00, 32'h85A3_0707},
    '{OP_WR,       1'b0, 5'h12, 8'h0F, 32'h0000_0000},
    '{OP_CHKMAP,   1'b0, 5'h00, 8'h00, 32'h8583_0707},
    '{OP_WR,       1'b0, 5'h13, 8'h00, 32'h0000_0000},   // fixed blocks
    '{OP_CHKMAP,   1'b0, 5'h00, 8'h00, 32'h8506_0707},
    '{OP_WR,       1'b1, 5'h01, 8'h3F, 32'h0000_0000},
    '{OP_WR,       1'b1, 5'h00, 8'h12, 32'h0000_0000},
    '{OP_WR,       1'b0, 5'h13, 8'h10, 32'h0000_0000},   // last ROM block
    '{OP_CHKMAP,   1'b0, 5'h00, 8'h00, 32'h827E_7F41},
    // old peripheral slots read zero and leave the kept registers alone
    '{OP_WR,       1'b0, 5'h05, 8'hA5, 32'h0000_0000},
    '{OP_RD,       1'b0, 5'h05, 8'h00, 32'h0000_0000},
    '{OP_WR,       1'b0, 5'h15, 8'h5A, 32'h0000_0000},
    '{OP_RD,       1'b0, 5'h15, 8'h00, 32'h0000_0000},
    '{OP_RD,       1'b0, 5'h10, 8'h00, 32'h0000_0012},   // written through the zero page
    '{OP_RD,       1'b0, 5'h11, 8'h00, 32'h0000_003F},
    '{OP_RD,       1'b0, 5'h12, 8'h00, 32'h0000_000F},
    '{OP_RD,       1'b0, 5'h13, 8'h00, 32'h0000_0010},
    // bootrom strobes
    '{OP_WR,       1'b0, 5'h13, 8'h24, 32'h0000_0000},   // only $E000 read-only
    '{OP_FLAGS,    1'b0, 5'h00, 8'h00, 32'h0000_0006},
    '{OP_MAP,      1'b0, 5'h00, 8'h00, 32'h0000_0000},
    '{OP_FLAGS,    1'b0, 5'h00, 8'h00, 32'h0000_0016},
    '{OP_WR,       1'b0, 5'h13, 8'hE0, 32'h0000_0000},
    '{OP_FLAGS,    1'b0, 5'h00, 8'h00, 32'h0000_001C},
    '{OP_UNMAP,    1'b0, 5'h00, 8'h00, 32'h0000_0000},
    '{OP_FLAGS,    1'b0, 5'h00, 8'h00, 32'h0000_0004},
    '{OP_RD,       1'b0, 5'h13, 8'h00, 32'h0000_0020},
    '{OP_WR,       1'b0, 5'h13, 8'hC0, 32'h0000_0000},
    '{OP_UNMAP_WR, 1'b0, 5'h13, 8'hDA, 32'h0000_0000},   // write is lost
    '{OP_RD,       1'b0, 5'h13, 8'h00, 32'h0000_0000},
    // SYSCTRL lock
    '{OP_PULSE,    1'b0, 5'h14, 8'h43, 32'h0000_0000},   // still locked
    '{OP_RD,       1'b0, 5'h14, 8'h00, 32'h0000_0000},
    '{OP_WR,       1'b0, 5'h14, 8'h80, 32'h0000_0000},
    '{OP_PULSE,    1'b0, 5'h14, 8'h43, 32'h0000_0003},
    '{OP_RD,       1'b0, 5'h14, 8'h00, 32'h0000_0040},
    '{OP_PULSE,    1'b0, 5'h14, 8'h03, 32'h0000_0000},   // locked again
    '{OP_RD,       1'b0, 5'h14, 8'h00, 32'h0000_0040},
    '{OP_WR,       1'b0, 5'h14, 8'h80, 32'h0000_0000},
    '{OP_WR,       1'b0, 5'h14, 8'hC1, 32'h0000_0000},   // not the key so it stays unlocked
    '{OP_PULSE,    1'b0, 5'h14, 8'h02, 32'h0000_0002},
    '{OP_RD,       1'b0, 5'h14, 8'h00, 32'h0000_0000}
};

`endif

// File: sim/tb_sysregs.sv
// testbench for the system register block
// runs the vector table through bus accesses, bootrom strobes and map checks
`timescale 1ns/1ns
`default_nettype none

module tb_sysregs;
    import sysregs_map_pkg::*;
    import memmap_pkg::*;

    typedef enum logic [3:0] {
        OP_WR,          // bus write
        OP_RD,          // bus read, expected byte
        OP_RND,         // random byte written then read back
        OP_MAP,
        OP_UNMAP,
        OP_UNMAP_WR,    // unmap strobe together with a bus write
        OP_CHKMAP,
        OP_FLAGS,
        OP_PULSE        // SYSCTRL write and request pulse check
    } op_t;

    typedef struct packed {
        op_t         op;
        logic        zp;
        reg_off_t    addr;
        logic [7:0]  data;
        logic [31:0] exp;
    } row_t;

    `include "tb_sysregs_vectors.svh"

    logic       clk;
    logic       resetn;
    reg_off_t   slv_addr;
    logic [7:0] slv_datawr;
    logic       slv_datawr_valid;
    logic [7:0] slv_datard;
    logic       slv_req;
    logic       slv_req_bregs;
    logic       slv_rwn;
    block_t     mm_ab;
    block_t     mm_cd;
    block_t     mm_ef;
    block_t     mm_vp;
    logic       bootrom_ef;
    logic       auto_unmap;
    logic       mirror_zp;
    logic [1:0] rdonly_cdef;
    logic       map_bootrom;
    logic       unmap_bootrom;
    logic       abrt02_en;
    logic       cpu_stop_req;
    logic       cpu_reset_req;

    sysregs_top DUT (
        .clk                   (clk),
        .resetn                (resetn),
        .slv_addr_i            (slv_addr),
        .slv_datawr_i          (slv_datawr),
        .slv_datawr_valid_i    (slv_datawr_valid),
        .slv_datard_o          (slv_datard),
        .slv_req_i             (slv_req),
        .slv_req_bregs_i       (slv_req_bregs),
        .slv_rwn_i             (slv_rwn),
        .mm_block_ab_o         (mm_ab),
        .mm_block_cd_o         (mm_cd),
        .mm_block_ef_o         (mm_ef),
        .mm_vp_block_ef_o      (mm_vp),
        .bootrom_in_block_ef_o (bootrom_ef),
        .auto_unmap_bootrom_o  (auto_unmap),
        .mirror_bregs_zp_o     (mirror_zp),
        .rdonly_cdef_o         (rdonly_cdef),
        .map_bootrom_i         (map_bootrom),
        .unmap_bootrom_i       (unmap_bootrom),
        .abrt02_en_o           (abrt02_en),
        .cpu_stop_req_o        (cpu_stop_req),
        .cpu_reset_req_o       (cpu_reset_req)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;       // 8 ns period

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_run($sformatf("[ERROR] t=%0t %s expected %02h actual %02h",
                               $time, name, exp, act));
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t act);
        if (act !== exp)
            stop_run($sformatf("[ERROR] t=%0t %s expected %02h actual %02h",
                               $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("[ERROR] t=%0t %s expected %b actual %b",
                               $time, name, exp, act));
    endtask

    task automatic bus_idle();
        slv_req          = 1'b0;
        slv_req_bregs    = 1'b0;
        slv_rwn          = 1'b1;
        slv_datawr_valid = 1'b0;
        map_bootrom      = 1'b0;
        unmap_bootrom    = 1'b0;
    endtask

    // inputs change 1 ns after the rising edge, then return to idle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        bus_idle();
    endtask

    task automatic drive_write(input logic zp, input reg_off_t addr, input logic [7:0] data);
        slv_addr         = addr;
        slv_req          = !zp;
        slv_req_bregs    = zp;     // zero-page path selects by bit 0 only
        slv_rwn          = 1'b0;
        slv_datawr       = data;
        slv_datawr_valid = 1'b1;
    endtask

    task automatic drive_read(input logic zp, input reg_off_t addr);
        slv_addr      = addr;
        slv_req       = !zp;
        slv_req_bregs = zp;
        slv_rwn       = 1'b1;
    endtask

    task automatic check_pulses(input logic stop_exp, input logic reset_exp);
        check_bit("cpu_stop_req_o", stop_exp, cpu_stop_req);
        check_bit("cpu_reset_req_o", reset_exp, cpu_reset_req);
    endtask

    task automatic run_row(input row_t r);
        logic [7:0] rnd;
        int         n;
        case (r.op)
            OP_WR, OP_UNMAP_WR:
            begin
                drive_write(r.zp, r.addr, r.data);
                unmap_bootrom = (r.op == OP_UNMAP_WR);
                next_cycle();
            end
            OP_RD:
            begin
                drive_read(r.zp, r.addr);
                @(negedge clk);         // read data is combinational, settled by now
                check_byte("slv_datard_o", r.exp[7:0], slv_datard);
                next_cycle();
            end
            OP_RND:
            begin
                rnd = 8'($urandom);
                drive_write(r.zp, r.addr, rnd);
                next_cycle();
                drive_read(r.zp, r.addr);
                @(negedge clk);
                check_byte("slv_datard_o", rnd, slv_datard);
                next_cycle();
            end
            OP_MAP:
            begin
                map_bootrom = 1'b1;
                next_cycle();
            end
            OP_UNMAP:
            begin
                unmap_bootrom = 1'b1;
                next_cycle();
            end
            OP_CHKMAP:
            begin
                repeat (2) @(negedge clk);      // register edge, then mapper edge
                check_block("mm_block_ab_o", r.exp[31:24], mm_ab);
                check_block("mm_block_cd_o", r.exp[23:16], mm_cd);
                check_block("mm_block_ef_o", r.exp[15:8], mm_ef);
                check_block("mm_vp_block_ef_o", r.exp[7:0], mm_vp);
                next_cycle();
            end
            OP_FLAGS:
            begin
                @(negedge clk);
                check_bit("bootrom_in_block_ef_o", r.exp[4], bootrom_ef);
                check_bit("auto_unmap_bootrom_o", r.exp[3], auto_unmap);
                check_bit("mirror_bregs_zp_o", r.exp[2], mirror_zp);
                check_bit("rdonly_cdef_o[1]", r.exp[1], rdonly_cdef[1]);
                check_bit("rdonly_cdef_o[0]", r.exp[0], rdonly_cdef[0]);
                next_cycle();
            end
            OP_PULSE:
            begin
                drive_write(1'b0, r.addr, r.data);
                next_cycle();
                if (r.exp[1:0] != 2'b00)
                begin
                    n = 0;
                    @(negedge clk);
                    while (!cpu_stop_req && !cpu_reset_req && n < 8)
                    begin
                        @(negedge clk);
                        n++;
                    end
                    if (!cpu_stop_req && !cpu_reset_req)
                        stop_run("timeout: no CPU request pulse after an unlocked SYSCTRL write");
                    check_pulses(r.exp[1], r.exp[0]);
                    @(negedge clk);
                    check_pulses(1'b0, 1'b0);       // one cycle wide
                end
                else
                begin
                    repeat (3)
                    begin
                        @(negedge clk);
                        check_pulses(1'b0, 1'b0);
                    end
                end
                next_cycle();
            end
            default: stop_run("unknown operation in the vector table");
        endcase
    endtask

    initial
    begin
        void'($urandom(32'hb74add3b));
        resetn     = 1'b0;
        slv_addr   = '0;
        slv_datawr = '0;
        bus_idle();
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        check_pulses(1'b0, 1'b0);
        check_bit("abrt02_en_o", 1'b0, abrt02_en);
        next_cycle();
        foreach (vectors[i])
            run_row(vectors[i]);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+sim
common/sysregs_map_pkg.sv
common/memmap_pkg.sv
verilog/reg_decode.sv
verilog/sysreg_file.sv
verilog/sysctrl_guard.sv
verilog/block_mapper.sv
verilog/sysregs_top.sv
sim/tb_sysregs.sv

// File: Makefile
SIM = obj_dir/Vtb_sysregs

$(SIM): filelist.f common/*.sv verilog/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --top-module tb_sysregs -f filelist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
